/* Makefile */
SIM       = verilator
SIM_FLAGS = --binary --timing --assert -Wno-fatal -j 0
TOP       = decode_tb
FILE_LIST = all.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) -f $(FILE_LIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "TEST RESULT: PASS" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* all.f */
+incdir+design
design/isa_pkg.sv
design/pipeline_pkg.sv
design/field_decoder.sv
design/trap_detector.sv
design/decode_stage.sv
sim/clock_gen.sv
sim/decode_properties.sv
sim/decode_tb.sv

/* design/decode_defs.svh */
/*
 * Decode stage constants
 * Instruction and register geometry, thread count and the
 * special register numbers shared by the decoder and its packages
 */

`ifndef DECODE_DEFS_SVH
`define DECODE_DEFS_SVH

// Width of a fetched instruction word
`define INSTR_WIDTH 32

// Hardware threads sharing the pipeline
`define NUM_THREADS 4

// Width of a scalar register select
`define REG_IDX_WIDTH 5

// Register number that reads as the program counter
`define REG_PC 31

// Register number written with the return address by a call
`define REG_RA 30

// All-zero instruction word decodes as a NOP
`define INSTRUCTION_NOP 32'h0000_0000

`endif

/* design/decode_stage.sv */
/*
 * Instruction decode stage
 * Merges field decode and trap detection, gates operand flags on a
 * trap or NOP and registers the decoded record one cycle later
 */

`timescale 1ns/1ps

`include "decode_defs.svh"

module decode_stage
    import isa_pkg::*;
    import pipeline_pkg::*;
(
    input logic clk,
    input logic reset,
    input logic fetch_valid,
    input scalar_t fetch_instruction,
    input scalar_t fetch_pc,
    input thread_idx_t fetch_thread_idx,
    input fetch_fault_t fetch_faults,
    input thread_hold_t thread_hold,
    input thread_bitmap_t interrupt_en,
    input thread_bitmap_t interrupt_pending,
    input logic rollback_en,
    input thread_idx_t rollback_thread_idx,
    output decoded_instruction_t id_instruction,
    output logic id_instruction_valid,
    output thread_idx_t id_thread_idx
);

    field_decode_t fields;
    logic has_trap;
    trap_cause_t trap_cause;
    logic is_nop;
    logic suppress;
    decoded_instruction_t instr_nxt;

    field_decoder field_decoder_i (
        .instruction(fetch_instruction),
        .fields(fields)
    );

    trap_detector trap_detector_i (
        .instruction(fetch_instruction),
        .illegal(fields.illegal),
        .faults(fetch_faults),
        .thread_idx(fetch_thread_idx),
        .hold(thread_hold),
        .interrupt_en(interrupt_en),
        .interrupt_pending(interrupt_pending),
        .has_trap(has_trap),
        .trap_cause(trap_cause)
    );

    assign is_nop = fetch_instruction == `INSTRUCTION_NOP;
    assign suppress = has_trap || is_nop;

    // Trapped and NOP instructions touch no registers and no memory
    always_comb
    begin
        instr_nxt.has_scalar1 = fields.has_scalar1 && !suppress;
        instr_nxt.scalar_sel1 = fields.scalar_sel1;
        instr_nxt.has_scalar2 = fields.has_scalar2 && !suppress;
        instr_nxt.scalar_sel2 = fields.scalar_sel2;
        instr_nxt.has_dest = fields.has_dest && !suppress;
        instr_nxt.dest_reg = fields.dest_reg;
        instr_nxt.alu_op = fields.alu_op;
        instr_nxt.op1_src = fields.op1_src;
        instr_nxt.op2_src = fields.op2_src;
        instr_nxt.immediate_value = fields.immediate_value;
        instr_nxt.has_trap = has_trap;
        instr_nxt.trap_cause = trap_cause;
        instr_nxt.is_branch = fields.is_branch && !suppress;
        instr_nxt.branch_type = fields.branch_type;
        instr_nxt.is_memory_access = fields.is_memory_access && !suppress;
        instr_nxt.memory_access_type = fields.memory_access_type;
        instr_nxt.is_load = fields.is_load;
        instr_nxt.pipeline_sel = has_trap ? PIPE_SCYCLE_ARITH : fields.pipeline_sel;
        instr_nxt.pc = fetch_pc;
    end

    always_ff @(posedge clk)
    begin
        id_instruction <= instr_nxt;
        id_thread_idx <= fetch_thread_idx;
    end

    // Fetch faults ride along as valid instructions so the trap is taken
    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
            id_instruction_valid <= 1'b0;
        else
            id_instruction_valid <= (fetch_valid || fetch_faults.tlb_miss
                || fetch_faults.alignment_fault)
                && !(rollback_en && rollback_thread_idx == fetch_thread_idx);
    end

endmodule

/* design/field_decoder.sv */
/*
 * Instruction field decoder
 * Detects the R, I, M and B formats and extracts register selects,
 * the sign-extended immediate, ALU operation and pipeline choice
 */

`timescale 1ns/1ps

`include "decode_defs.svh"

module field_decoder
    import isa_pkg::*;
    import pipeline_pkg::*;
(
    input scalar_t instruction,
    output field_decode_t fields
);

    logic is_fmt_r;
    logic is_fmt_i;
    logic is_fmt_m;
    logic is_fmt_b;
    logic is_call;
    branch_type_t branch_type;
    memory_op_t mem_op;
    alu_op_t alu_op;
    logic illegal;
    logic has_scalar1;
    logic has_scalar2;
    logic has_dest;
    logic [`REG_IDX_WIDTH-1:0] scalar_sel2;
    scalar_t immediate;
    op2_src_t op2_base;

    assign is_fmt_r = instruction[31:29] == 3'b110 && instruction[28:26] == 3'b000;
    assign is_fmt_i = !instruction[31] && instruction[30:28] == 3'b000;
    assign is_fmt_m = instruction[31:30] == 2'b10;
    assign is_fmt_b = instruction[31:28] == 4'b1111;

    assign branch_type = branch_type_t'(instruction[27:25]);
    assign mem_op = memory_op_t'(instruction[28:25]);
    assign is_call = is_fmt_b
        && (branch_type == BRANCH_CALL_OFFSET || branch_type == BRANCH_CALL_REGISTER);

    // Operand presence, second select and immediate per format
    always_comb
    begin
        illegal = 1'b0;
        has_scalar1 = 1'b0;
        has_scalar2 = 1'b0;
        has_dest = 1'b0;
        scalar_sel2 = instruction[19:15];
        immediate = '0;
        op2_base = OP2_SRC_SCALAR2;

        if (is_fmt_r)
        begin
            has_scalar1 = 1'b1;
            has_scalar2 = 1'b1;
            has_dest = 1'b1;
        end
        else if (is_fmt_i)
        begin
            has_scalar1 = 1'b1;
            has_dest = 1'b1;
            immediate = scalar_t'($signed(instruction[22:10]));
            op2_base = OP2_SRC_IMMEDIATE;
        end
        else if (is_fmt_m)
        begin
            immediate = scalar_t'($signed(instruction[24:10]));
            op2_base = OP2_SRC_IMMEDIATE;
            if (mem_op > MEM_SYNC)
                illegal = 1'b1;
            else
            begin
                has_scalar1 = 1'b1;
                if (instruction[29])
                    has_dest = 1'b1;
                else
                begin
                    // Store value comes from the dest field position
                    has_scalar2 = 1'b1;
                    scalar_sel2 = instruction[9:5];
                end
            end
        end
        else if (is_fmt_b)
        begin
            immediate = scalar_t'($signed(instruction[24:5]));
            op2_base = OP2_SRC_IMMEDIATE;
            has_scalar1 = branch_type != BRANCH_ALWAYS && branch_type != BRANCH_CALL_OFFSET;
            if (is_call || branch_type == BRANCH_LINK_REGISTER)
            begin
                // Link value is the PC, routed through the second operand
                has_scalar2 = 1'b1;
                has_dest = 1'b1;
                scalar_sel2 = `REG_PC;
                op2_base = OP2_SRC_SCALAR2;
            end
        end
        else
            illegal = 1'b1;
    end

    // A call becomes move ra, pc
    always_comb
    begin
        if (is_fmt_i)
            alu_op = alu_op_t'({1'b0, instruction[27:23]});
        else if (is_call)
            alu_op = OP_MOVE;
        else
            alu_op = alu_op_t'(instruction[25:20]);
    end

    assign fields.illegal = illegal;
    assign fields.has_scalar1 = has_scalar1;
    assign fields.has_scalar2 = has_scalar2;
    assign fields.has_dest = has_dest;
    assign fields.scalar_sel1 = instruction[4:0];
    assign fields.scalar_sel2 = scalar_sel2;
    assign fields.dest_reg = is_call ? `REG_IDX_WIDTH'(`REG_RA) : instruction[9:5];
    assign fields.immediate_value = immediate;
    assign fields.alu_op = alu_op;

    // PC register as an operand reads the fetch PC
    assign fields.op1_src = instruction[4:0] == `REG_PC ? OP1_SRC_PC : OP1_SRC_SCALAR1;
    assign fields.op2_src = (op2_base == OP2_SRC_SCALAR2 && scalar_sel2 == `REG_PC)
        ? OP2_SRC_PC : op2_base;

    assign fields.is_branch = is_fmt_b;
    assign fields.branch_type = branch_type;
    assign fields.is_memory_access = is_fmt_m;
    assign fields.memory_access_type = mem_op;
    assign fields.is_load = is_fmt_m && instruction[29];

    always_comb
    begin
        if ((is_fmt_r || is_fmt_i) && (alu_op[5] || alu_op == OP_MULL_I
            || alu_op == OP_MULH_U || alu_op == OP_MULH_I || alu_op == OP_FTOI))
            fields.pipeline_sel = PIPE_MCYCLE_ARITH;
        else if (is_fmt_m)
            fields.pipeline_sel = PIPE_MEM;
        else
            fields.pipeline_sel = PIPE_SCYCLE_ARITH;
    end

endmodule

/* design/isa_pkg.sv */
/*
 * Instruction set types
 * ALU operations, branch kinds, memory access kinds, trap causes
 * and the operand and pipeline selectors produced by decode
 */

package isa_pkg;

    // Bit 5 set marks a floating-point operation
    typedef enum logic [5:0] {
        OP_OR       = 6'b000000,
        OP_AND      = 6'b000001,
        OP_XOR      = 6'b000011,
        OP_ADD_I    = 6'b000101,
        OP_SUB_I    = 6'b000110,
        OP_MULL_I   = 6'b000111,
        OP_MULH_U   = 6'b001000,
        OP_ASHR     = 6'b001001,
        OP_SHR      = 6'b001010,
        OP_SHL      = 6'b001011,
        OP_CLZ      = 6'b001100,
        OP_CTZ      = 6'b001110,
        OP_MOVE     = 6'b001111,
        OP_CMPEQ_I  = 6'b010000,
        OP_CMPNE_I  = 6'b010001,
        OP_CMPGT_I  = 6'b010010,
        OP_CMPLT_I  = 6'b010100,
        OP_SYSCALL  = 6'b011001,
        OP_FTOI     = 6'b011011,
        OP_SEXT8    = 6'b011101,
        OP_SEXT16   = 6'b011110,
        OP_MULH_I   = 6'b011111,
        OP_ADD_F    = 6'b100000,
        OP_SUB_F    = 6'b100001,
        OP_MUL_F    = 6'b100010,
        OP_ITOF     = 6'b101010
    } alu_op_t;

    // Kinds 4 and 6 are calls
    typedef enum logic [2:0] {
        BRANCH_REGISTER      = 3'd0,
        BRANCH_ZERO          = 3'd1,
        BRANCH_NOT_ZERO      = 3'd2,
        BRANCH_ALWAYS        = 3'd3,
        BRANCH_CALL_OFFSET   = 3'd4,
        BRANCH_RETURN        = 3'd5,
        BRANCH_CALL_REGISTER = 3'd6,
        BRANCH_LINK_REGISTER = 3'd7
    } branch_type_t;

    typedef enum logic [3:0] {
        MEM_B    = 4'd0,
        MEM_BX   = 4'd1,
        MEM_S    = 4'd2,
        MEM_SX   = 4'd3,
        MEM_L    = 4'd4,
        MEM_SYNC = 4'd5
    } memory_op_t;

    typedef enum logic [3:0] {
        TT_RESET               = 4'd0,
        TT_ILLEGAL_INSTRUCTION = 4'd1,
        TT_INTERRUPT           = 4'd3,
        TT_SYSCALL             = 4'd4,
        TT_UNALIGNED_ACCESS    = 4'd5,
        TT_TLB_MISS            = 4'd7
    } trap_cause_t;

    typedef enum logic [1:0] {
        OP2_SRC_SCALAR2,
        OP2_SRC_IMMEDIATE,
        OP2_SRC_PC
    } op2_src_t;

    typedef enum logic {
        OP1_SRC_SCALAR1,
        OP1_SRC_PC
    } op1_src_t;

    typedef enum logic [1:0] {
        PIPE_SCYCLE_ARITH,
        PIPE_MCYCLE_ARITH,
        PIPE_MEM
    } pipe_sel_t;

endpackage

/* design/pipeline_pkg.sv */
/*
 * Pipeline record types
 * Thread bookkeeping, fetch fault flags, raw field decode results
 * and the registered decoded instruction record
 */

`include "decode_defs.svh"

package pipeline_pkg;
    import isa_pkg::*;

    typedef logic [`INSTR_WIDTH-1:0] scalar_t;
    typedef logic [$clog2(`NUM_THREADS)-1:0] thread_idx_t;
    typedef logic [`NUM_THREADS-1:0] thread_bitmap_t;

    typedef struct packed {
        logic tlb_miss;
        logic alignment_fault;
    } fetch_fault_t;

    // Threads with the first half of a two-part access already issued
    typedef struct packed {
        thread_bitmap_t sync_load_pending;
        thread_bitmap_t sync_store_pending;
        thread_bitmap_t io_pending;
    } thread_hold_t;

    // Raw decode output, operand flags not yet gated by trap or NOP
    typedef struct packed {
        logic illegal;
        logic has_scalar1;
        logic has_scalar2;
        logic has_dest;
        logic [`REG_IDX_WIDTH-1:0] scalar_sel1;
        logic [`REG_IDX_WIDTH-1:0] scalar_sel2;
        logic [`REG_IDX_WIDTH-1:0] dest_reg;
        scalar_t immediate_value;
        alu_op_t alu_op;
        op1_src_t op1_src;
        op2_src_t op2_src;
        logic is_branch;
        branch_type_t branch_type;
        logic is_memory_access;
        memory_op_t memory_access_type;
        logic is_load;
        pipe_sel_t pipeline_sel;
    } field_decode_t;

    typedef struct packed {
        logic has_scalar1;
        logic [`REG_IDX_WIDTH-1:0] scalar_sel1;
        logic has_scalar2;
        logic [`REG_IDX_WIDTH-1:0] scalar_sel2;
        logic has_dest;
        logic [`REG_IDX_WIDTH-1:0] dest_reg;
        alu_op_t alu_op;
        op1_src_t op1_src;
        op2_src_t op2_src;
        scalar_t immediate_value;
        logic has_trap;
        trap_cause_t trap_cause;
        logic is_branch;
        branch_type_t branch_type;
        logic is_memory_access;
        memory_op_t memory_access_type;
        logic is_load;
        pipe_sel_t pipeline_sel;
        scalar_t pc;
    } decoded_instruction_t;

endpackage

/* design/trap_detector.sv */
/*
 * Trap detector
 * Masks interrupts for threads in the middle of a two-part access
 * and reduces all trap sources to one cause by fixed priority
 */

`timescale 1ns/1ps

module trap_detector
    import isa_pkg::*;
    import pipeline_pkg::*;
(
    input scalar_t instruction,
    input logic illegal,
    input fetch_fault_t faults,
    input thread_idx_t thread_idx,
    input thread_hold_t hold,
    input thread_bitmap_t interrupt_en,
    input thread_bitmap_t interrupt_pending,
    output logic has_trap,
    output trap_cause_t trap_cause
);

    thread_bitmap_t masked_interrupts;
    logic raise_interrupt;
    logic is_syscall;

    // The first half of a synchronized or I/O access has changed state,
    // so an interrupt must wait until the second half has issued
    assign masked_interrupts = interrupt_pending & interrupt_en
        & ~hold.sync_load_pending & ~hold.sync_store_pending & ~hold.io_pending;
    assign raise_interrupt = masked_interrupts[thread_idx];

    assign is_syscall = instruction[31:26] == 6'b110000
        && instruction[25:20] == OP_SYSCALL;

    assign has_trap = raise_interrupt || faults.tlb_miss || faults.alignment_fault
        || illegal || is_syscall;

    // TLB miss ahead of alignment, the translation is not valid on a miss
    always_comb
    begin
        if (raise_interrupt)
            trap_cause = TT_INTERRUPT;
        else if (faults.tlb_miss)
            trap_cause = TT_TLB_MISS;
        else if (faults.alignment_fault)
            trap_cause = TT_UNALIGNED_ACCESS;
        else if (illegal)
            trap_cause = TT_ILLEGAL_INSTRUCTION;
        else if (is_syscall)
            trap_cause = TT_SYSCALL;
        else
            trap_cause = TT_RESET;
    end

endmodule

/* sim/clock_gen.sv */
/*
 * Testbench clock and reset source
 * Free-running clock with a reset held for a fixed number of cycles
 */

`timescale 1ns/1ps

module clock_gen #(
    parameter int PERIOD_NS = 8,
    parameter int RESET_CYCLES = 3
)
(
    output logic clk,
    output logic reset
);

    initial
    begin
        clk = 1'b0;
        forever
            #(PERIOD_NS / 2) clk = ~clk;
    end

    // Rising edge shortly after time zero so the DUT flop sees it
    initial
    begin
        reset = 1'b0;
        #1 reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
    end

endmodule

/* sim/decode_properties.sv */
/*
 * Decode stage output properties
 * Reset behavior of valid and consistency of the registered trap fields
 */

`timescale 1ns/1ps

module decode_properties
    import isa_pkg::*;
    import pipeline_pkg::*;
(
    input logic clk,
    input logic reset,
    input decoded_instruction_t id_instruction,
    input logic id_instruction_valid
);

    int failure_count = 0;

    valid_low_in_reset: assert property (@(posedge clk) reset |-> !id_instruction_valid)
    else
    begin
        $error("id_instruction_valid is high while reset is asserted");
        failure_count++;
    end

    // A trapped instruction must never write a register
    trap_has_no_dest: assert property (@(posedge clk) disable iff (reset)
        id_instruction_valid && id_instruction.has_trap |-> !id_instruction.has_dest)
    else
    begin
        $error("Registered trap still has has_dest set");
        failure_count++;
    end

    cause_matches_trap: assert property (@(posedge clk) disable iff (reset)
        id_instruction_valid
        |-> (id_instruction.trap_cause != TT_RESET) == id_instruction.has_trap)
    else
    begin
        $error("trap_cause and has_trap disagree");
        failure_count++;
    end

endmodule

bind decode_stage decode_properties properties_i (
    .clk(clk),
    .reset(reset),
    .id_instruction(id_instruction),
    .id_instruction_valid(id_instruction_valid)
);

/* sim/decode_tb.sv */
/*
 * Decode stage testbench
 * Applies a table of fetched instructions, faults and interrupt state
 * and checks the registered decode record one cycle later
 */

`timescale 1ns/1ps

`include "decode_defs.svh"

module decode_tb
    import isa_pkg::*;
    import pipeline_pkg::*;
();

    localparam int CLK_PERIOD = 8;
    localparam int RESET_CYCLES = 3;

    typedef struct packed {
        scalar_t instr;
        logic valid;
        thread_idx_t thread;
        fetch_fault_t faults;
        thread_hold_t hold;
        thread_bitmap_t int_en;
        thread_bitmap_t int_pending;
        logic rb_en;
        thread_idx_t rb_thread;
        logic exp_valid;
        logic exp_trap;
        trap_cause_t exp_cause;
        logic exp_s1;
        logic exp_s2;
        logic exp_dest;
        logic check_fields;
        logic check_alu;
        logic exp_branch;
        logic exp_mem;
        logic exp_load;
        branch_type_t exp_btype;
        memory_op_t exp_mop;
        op1_src_t exp_op1;
        logic [4:0] exp_sel1;
        logic [4:0] exp_sel2;
        logic [4:0] exp_dreg;
        scalar_t exp_imm;
        alu_op_t exp_alu;
        op2_src_t exp_op2;
        pipe_sel_t exp_pipe;
    } test_row_t;

    logic clk;
    logic reset;
    logic fetch_valid;
    scalar_t fetch_instruction;
    scalar_t fetch_pc;
    thread_idx_t fetch_thread_idx;
    fetch_fault_t fetch_faults;
    thread_hold_t thread_hold;
    thread_bitmap_t interrupt_en;
    thread_bitmap_t interrupt_pending;
    logic rollback_en;
    thread_idx_t rollback_thread_idx;
    decoded_instruction_t id_instruction;
    logic id_instruction_valid;
    thread_idx_t id_thread_idx;

    test_row_t rows[$];
    string names[$];
    logic table_ready = 1'b0;
    int seed = 32'hdd7c_abd6;

    clock_gen #(
        .PERIOD_NS(CLK_PERIOD),
        .RESET_CYCLES(RESET_CYCLES)
    ) clock_gen_i (
        .clk(clk),
        .reset(reset)
    );

    decode_stage decode_stage_i (
        .clk(clk),
        .reset(reset),
        .fetch_valid(fetch_valid),
        .fetch_instruction(fetch_instruction),
        .fetch_pc(fetch_pc),
        .fetch_thread_idx(fetch_thread_idx),
        .fetch_faults(fetch_faults),
        .thread_hold(thread_hold),
        .interrupt_en(interrupt_en),
        .interrupt_pending(interrupt_pending),
        .rollback_en(rollback_en),
        .rollback_thread_idx(rollback_thread_idx),
        .id_instruction(id_instruction),
        .id_instruction_valid(id_instruction_valid),
        .id_thread_idx(id_thread_idx)
    );

    // Registers 0 to 29 only so neither PC nor RA is picked by chance
    function automatic logic [4:0] random_reg();
        return 5'($unsigned($random(seed)) % 30);
    endfunction

    function automatic scalar_t sign_extend(scalar_t value, int width);
        return scalar_t'($signed(value << (32 - width)) >>> (32 - width));
    endfunction

    function automatic test_row_t plain_row(scalar_t instr);
        test_row_t row;
        row = '0;
        row.instr = instr;
        row.valid = 1'b1;
        row.exp_valid = 1'b1;
        row.exp_cause = TT_RESET;
        return row;
    endfunction

    // uses is {has_scalar1, has_scalar2, has_dest}
    function automatic test_row_t decode_row(scalar_t instr, logic [2:0] uses,
        logic [4:0] sel1, logic [4:0] sel2, logic [4:0] dreg, scalar_t imm,
        op2_src_t op2, pipe_sel_t pipe);
        test_row_t row;
        row = plain_row(instr);
        {row.exp_s1, row.exp_s2, row.exp_dest} = uses;
        row.check_fields = 1'b1;
        row.exp_sel1 = sel1;
        row.exp_sel2 = sel2;
        row.exp_dreg = dreg;
        row.exp_imm = imm;
        row.exp_op2 = op2;
        row.exp_pipe = pipe;
        return row;
    endfunction

    function automatic test_row_t with_alu(test_row_t row, alu_op_t op);
        row.check_alu = 1'b1;
        row.exp_alu = op;
        return row;
    endfunction

    function automatic test_row_t with_branch(test_row_t row, branch_type_t kind);
        row.exp_branch = 1'b1;
        row.exp_btype = kind;
        return row;
    endfunction

    function automatic test_row_t with_memory(test_row_t row, memory_op_t kind, logic load);
        row.exp_mem = 1'b1;
        row.exp_mop = kind;
        row.exp_load = load;
        return row;
    endfunction

    // Trapped instructions expect every operand flag cleared
    function automatic test_row_t trap_row(scalar_t instr, fetch_fault_t faults,
        trap_cause_t cause);
        test_row_t row;
        row = plain_row(instr);
        row.faults = faults;
        row.exp_trap = 1'b1;
        row.exp_cause = cause;
        return row;
    endfunction

    function automatic test_row_t with_interrupt(test_row_t row, thread_idx_t thread);
        row.thread = thread;
        row.int_en = thread_bitmap_t'(1) << thread;
        row.int_pending = thread_bitmap_t'(1) << thread;
        return row;
    endfunction

    task automatic add_row(string name, test_row_t row);
        rows.push_back(row);
        names.push_back(name);
    endtask

    task automatic build_table();
        logic [4:0] rs1;
        logic [4:0] rs2;
        logic [4:0] rd;
        scalar_t instr;
        scalar_t illegal_instr;
        scalar_t syscall_instr;
        test_row_t row;

        rs1 = random_reg();
        rs2 = random_reg();
        rd = random_reg();
        illegal_instr = 32'he000_0000;
        syscall_instr = {6'b110000, OP_SYSCALL, rs2, 5'd0, rd, rs1};

        instr = {6'b110000, OP_ADD_I, rs2, 5'd0, rd, rs1};
        row = decode_row(instr, 3'b111, rs1, rs2, rd, '0, OP2_SRC_SCALAR2, PIPE_SCYCLE_ARITH);
        add_row("r_add", with_alu(row, OP_ADD_I));
        instr = {6'b110000, OP_MULL_I, rs2, 5'd0, rd, rs1};
        row = decode_row(instr, 3'b111, rs1, rs2, rd, '0, OP2_SRC_SCALAR2, PIPE_MCYCLE_ARITH);
        add_row("r_mull", with_alu(row, OP_MULL_I));
        instr = {6'b110000, OP_ADD_F, rs2, 5'd0, rd, rs1};
        row = decode_row(instr, 3'b111, rs1, rs2, rd, '0, OP2_SRC_SCALAR2, PIPE_MCYCLE_ARITH);
        add_row("r_add_f", with_alu(row, OP_ADD_F));
        instr = {6'b110000, OP_SUB_I, 5'(`REG_PC), 5'd0, rd, 5'(`REG_PC)};
        row = decode_row(instr, 3'b111, 5'(`REG_PC), 5'(`REG_PC), rd, '0, OP2_SRC_PC,
            PIPE_SCYCLE_ARITH);
        row.exp_op1 = OP1_SRC_PC;
        add_row("r_pc_operand", with_alu(row, OP_SUB_I));

        instr = {4'b0000, 5'(OP_ADD_I), 13'h1f05, rd, rs1};
        row = decode_row(instr, 3'b101, rs1, 5'd0, rd, sign_extend(32'h1f05, 13),
            OP2_SRC_IMMEDIATE, PIPE_SCYCLE_ARITH);
        add_row("i_add_negative", with_alu(row, OP_ADD_I));

        instr = {3'b101, MEM_L, 15'h4010, rd, rs1};
        row = decode_row(instr, 3'b101, rs1, 5'd0, rd, sign_extend(32'h4010, 15),
            OP2_SRC_IMMEDIATE, PIPE_MEM);
        add_row("m_load", with_memory(row, MEM_L, 1'b1));
        instr = {3'b100, MEM_S, 15'h0123, rs2, rs1};
        row = decode_row(instr, 3'b110, rs1, rs2, 5'd0, 32'h0123,
            OP2_SRC_IMMEDIATE, PIPE_MEM);
        add_row("m_store", with_memory(row, MEM_S, 1'b0));

        instr = {4'b1111, BRANCH_ZERO, 20'h80004, rs1};
        row = decode_row(instr, 3'b100, rs1, 5'd0, 5'd0, sign_extend(32'h80004, 20),
            OP2_SRC_IMMEDIATE, PIPE_SCYCLE_ARITH);
        add_row("b_zero", with_branch(row, BRANCH_ZERO));
        add_row("b_zero_interrupted",
            with_interrupt(trap_row(instr, 2'b00, TT_INTERRUPT), 2'd0));
        instr = {4'b1111, BRANCH_ALWAYS, 20'h00010, rs1};
        row = decode_row(instr, 3'b000, 5'd0, 5'd0, 5'd0, 32'h10,
            OP2_SRC_IMMEDIATE, PIPE_SCYCLE_ARITH);
        add_row("b_always", with_branch(row, BRANCH_ALWAYS));
        instr = {4'b1111, BRANCH_CALL_OFFSET, 20'hfffff, rs1};
        row = decode_row(instr, 3'b011, 5'd0, 5'(`REG_PC), 5'(`REG_RA), 32'hffff_ffff,
            OP2_SRC_PC, PIPE_SCYCLE_ARITH);
        add_row("b_call", with_branch(with_alu(row, OP_MOVE), BRANCH_CALL_OFFSET));
        instr = {4'b1111, BRANCH_CALL_REGISTER, 20'h00000, rs1};
        row = decode_row(instr, 3'b111, rs1, 5'(`REG_PC), 5'(`REG_RA), '0,
            OP2_SRC_PC, PIPE_SCYCLE_ARITH);
        add_row("b_call_register",
            with_branch(with_alu(row, OP_MOVE), BRANCH_CALL_REGISTER));

        add_row("nop", plain_row(`INSTRUCTION_NOP));
        add_row("illegal_format", trap_row(illegal_instr, 2'b00, TT_ILLEGAL_INSTRUCTION));
        instr = {3'b101, 4'd7, 15'h0, rd, rs1};
        add_row("illegal_memory_op", trap_row(instr, 2'b00, TT_ILLEGAL_INSTRUCTION));
        add_row("syscall", trap_row(syscall_instr, 2'b00, TT_SYSCALL));

        // Fault flags are {tlb_miss, alignment_fault}
        add_row("priority_interrupt",
            with_interrupt(trap_row(illegal_instr, 2'b11, TT_INTERRUPT), 2'd1));
        add_row("priority_tlb", trap_row(illegal_instr, 2'b11, TT_TLB_MISS));
        add_row("priority_alignment", trap_row(illegal_instr, 2'b01, TT_UNALIGNED_ACCESS));
        add_row("alignment_over_syscall",
            trap_row(syscall_instr, 2'b01, TT_UNALIGNED_ACCESS));

        row = with_interrupt(plain_row(`INSTRUCTION_NOP), 2'd2);
        row.hold.sync_load_pending = 4'b0100;
        add_row("hold_sync_load", row);
        row.hold = '0;
        row.hold.sync_store_pending = 4'b0100;
        add_row("hold_sync_store", row);
        row.hold = '0;
        row.hold.io_pending = 4'b0100;
        add_row("hold_io", row);
        row.hold.io_pending = 4'b1011;
        row.exp_trap = 1'b1;
        row.exp_cause = TT_INTERRUPT;
        add_row("hold_other_threads", row);
        row.hold = '0;
        add_row("interrupt_released", row);

        instr = {6'b110000, OP_ADD_I, rs2, 5'd0, rd, rs1};
        row = decode_row(instr, 3'b111, rs1, rs2, rd, '0, OP2_SRC_SCALAR2, PIPE_SCYCLE_ARITH);
        row.thread = 2'd1;
        row.rb_en = 1'b1;
        row.rb_thread = 2'd1;
        row.exp_valid = 1'b0;
        add_row("rollback_same_thread", row);
        row.rb_thread = 2'd3;
        row.exp_valid = 1'b1;
        add_row("rollback_other_thread", row);

        row = trap_row(`INSTRUCTION_NOP, 2'b10, TT_TLB_MISS);
        row.valid = 1'b0;
        add_row("fault_without_valid", row);
        row = plain_row(`INSTRUCTION_NOP);
        row.valid = 1'b0;
        row.exp_valid = 1'b0;
        add_row("idle", row);
    endtask

    task automatic check_value(string test_name, string field, logic [31:0] expected,
        logic [31:0] actual);
        if (actual !== expected)
        begin
            $display("Error: test %s field %s expected 0x%0h actual 0x%0h",
                test_name, field, expected, actual);
            $display("TEST RESULT: FAIL");
            $fatal(1, "Mismatch in test %s", test_name);
        end
    endtask

    task automatic drive_row(test_row_t row, scalar_t pc);
        fetch_valid <= row.valid;
        fetch_instruction <= row.instr;
        fetch_pc <= pc;
        fetch_thread_idx <= row.thread;
        fetch_faults <= row.faults;
        thread_hold <= row.hold;
        interrupt_en <= row.int_en;
        interrupt_pending <= row.int_pending;
        rollback_en <= row.rb_en;
        rollback_thread_idx <= row.rb_thread;
    endtask

    task automatic check_row(string name, test_row_t row, scalar_t pc);
        check_value(name, "valid", 32'(row.exp_valid), 32'(id_instruction_valid));
        if (row.exp_valid)
        begin
            check_value(name, "thread", 32'(row.thread), 32'(id_thread_idx));
            check_value(name, "pc", pc, id_instruction.pc);
            check_value(name, "has_trap", 32'(row.exp_trap), 32'(id_instruction.has_trap));
            check_value(name, "trap_cause", 32'(row.exp_cause),
                32'(id_instruction.trap_cause));
            check_value(name, "has_scalar1", 32'(row.exp_s1), 32'(id_instruction.has_scalar1));
            check_value(name, "has_scalar2", 32'(row.exp_s2), 32'(id_instruction.has_scalar2));
            check_value(name, "has_dest", 32'(row.exp_dest), 32'(id_instruction.has_dest));
            check_value(name, "is_branch", 32'(row.exp_branch),
                32'(id_instruction.is_branch));
            check_value(name, "is_memory_access", 32'(row.exp_mem),
                32'(id_instruction.is_memory_access));
            check_value(name, "pipeline_sel", 32'(row.exp_pipe),
                32'(id_instruction.pipeline_sel));
            if (row.check_fields)
            begin
                if (row.exp_s1)
                    check_value(name, "scalar_sel1", 32'(row.exp_sel1),
                        32'(id_instruction.scalar_sel1));
                if (row.exp_s2)
                    check_value(name, "scalar_sel2", 32'(row.exp_sel2),
                        32'(id_instruction.scalar_sel2));
                if (row.exp_dest)
                    check_value(name, "dest_reg", 32'(row.exp_dreg),
                        32'(id_instruction.dest_reg));
                check_value(name, "immediate", row.exp_imm, id_instruction.immediate_value);
                check_value(name, "op1_src", 32'(row.exp_op1), 32'(id_instruction.op1_src));
                check_value(name, "op2_src", 32'(row.exp_op2), 32'(id_instruction.op2_src));
                check_value(name, "is_load", 32'(row.exp_load), 32'(id_instruction.is_load));
                if (row.exp_branch)
                    check_value(name, "branch_type", 32'(row.exp_btype),
                        32'(id_instruction.branch_type));
                if (row.exp_mem)
                    check_value(name, "memory_access_type", 32'(row.exp_mop),
                        32'(id_instruction.memory_access_type));
                if (row.check_alu)
                    check_value(name, "alu_op", 32'(row.exp_alu), 32'(id_instruction.alu_op));
            end
        end
    endtask

    initial
    begin
        fetch_valid = 1'b0;
        fetch_instruction = '0;
        fetch_pc = '0;
        fetch_thread_idx = '0;
        fetch_faults = '0;
        thread_hold = '0;
        interrupt_en = '0;
        interrupt_pending = '0;
        rollback_en = 1'b0;
        rollback_thread_idx = '0;
        build_table();
        table_ready = 1'b1;

        wait (reset === 1'b1);
        wait (reset === 1'b0);
        repeat (2)
        begin
            @(negedge clk);
            check_value("after_reset", "valid", 32'd0, 32'(id_instruction_valid));
        end

        // One row per two cycles with the result sampled mid-cycle after the capture edge
        for (int i = 0; i < rows.size(); i++)
        begin
            @(posedge clk);
            drive_row(rows[i], 32'h0000_1000 + 32'(i * 4));
            @(posedge clk);
            @(negedge clk);
            check_row(names[i], rows[i], 32'h0000_1000 + 32'(i * 4));
        end

        if (decode_stage_i.properties_i.failure_count == 0)
        begin
            $display("TEST RESULT: PASS");
            $finish;
        end
        else
        begin
            $display("TEST RESULT: FAIL");
            $fatal(1, "Output properties failed during the run");
        end
    end

    // Watchdog
    initial
    begin
        wait (table_ready);
        #((rows.size() * 10 + RESET_CYCLES) * CLK_PERIOD);
        $display("Timeout: the table did not finish in the allowed number of cycles");
        $display("TEST RESULT: FAIL");
        $fatal(1, "Watchdog expired");
    end

endmodule
